// File: common/sad_pkg.sv
package sad_pkg;

    // window length, also the number of parallel lanes
    localparam int ref_samples = 32;
    localparam int bits_per_sample = 8;

    // accumulator width; the top bit doubles as saturation flag
    localparam int sad_width = 16;

    // host byte index, wide enough for the whole reference
    localparam int bytecnt_width = 7;

    localparam int lane_idx_width = $clog2(ref_samples);

    // host register map
    localparam logic [7:0] addr_reference         = 8'h20;
    localparam logic [7:0] addr_threshold         = 8'h21;
    localparam logic [7:0] addr_status            = 8'h22;
    localparam logic [7:0] addr_bits_per_sample   = 8'h23;
    localparam logic [7:0] addr_ref_samples       = 8'h24;
    localparam logic [7:0] addr_counter_width     = 8'h25;
    localparam logic [7:0] addr_multiple_triggers = 8'h26;

    typedef logic [bits_per_sample-1:0] sample_t;

    typedef logic [sad_width-1:0] sad_t;

    // one bit per lane
    typedef logic [ref_samples-1:0] lane_mask_t;

    // element k is reference sample k
    typedef sample_t [ref_samples-1:0] ref_array_t;

endpackage

// File: rtl/sad_regs.sv
module sad_regs (
    input  logic                              adc_sampleclk,
    input  logic                              reset,
    input  logic [7:0]                        reg_address,
    input  logic [sad_pkg::bytecnt_width-1:0] reg_bytecnt,
    input  logic [7:0]                        reg_datai,
    input  logic                              reg_read,
    input  logic                              reg_write,
    input  logic                              triggered,
    input  logic [15:0]                       num_triggers,
    output logic [7:0]                        reg_datao,
    output sad_pkg::ref_array_t               ref_wave,
    output sad_pkg::sad_t                     threshold,
    output logic                              multiple_triggers,
    output logic                              clear_status
);
    import sad_pkg::*;

    logic [31:0] threshold_wide;  // host always sees 4 bytes
    logic [23:0] status_word;
    logic        ref_hit;
    logic        thr_hit;
    logic        status_hit;

    assign threshold_wide = 32'(threshold);
    assign status_word    = {num_triggers, 7'b0, triggered};

    // byte index range checks
    assign ref_hit    = reg_bytecnt < bytecnt_width'(ref_samples);
    assign thr_hit    = reg_bytecnt < bytecnt_width'(4);
    assign status_hit = reg_bytecnt < bytecnt_width'(3);

    // reads are combinational and only valid with reg_read
    always_comb begin
        reg_datao = 8'h00;
        if (reg_read) begin
            case (reg_address)
                addr_reference: begin
                    if (ref_hit) begin
                        reg_datao = ref_wave[reg_bytecnt[lane_idx_width-1:0]];
                    end
                end
                addr_threshold: begin
                    if (thr_hit) begin
                        reg_datao = threshold_wide[8*reg_bytecnt[1:0] +: 8];
                    end
                end
                addr_status: begin
                    if (status_hit) begin
                        reg_datao = status_word[8*reg_bytecnt[1:0] +: 8];
                    end
                end
                addr_bits_per_sample:   reg_datao = 8'(bits_per_sample);
                addr_ref_samples:       reg_datao = 8'(ref_samples);
                addr_counter_width:     reg_datao = 8'(sad_width);
                addr_multiple_triggers: reg_datao = {7'b0, multiple_triggers};
                default:                reg_datao = 8'h00;
            endcase
        end
    end

    // reference byte k lands in sample k
    always_ff @(posedge adc_sampleclk) begin
        if (reg_write && reg_address == addr_reference && ref_hit) begin
            ref_wave[reg_bytecnt[lane_idx_width-1:0]] <= reg_datai;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            threshold         <= '0;
            multiple_triggers <= 1'b0;
            clear_status      <= 1'b0;
        end else begin
            // one pulse per status write, whatever the data
            clear_status <= reg_write && (reg_address == addr_status);
            if (reg_write) begin
                case (reg_address)
                    addr_threshold: begin
                        // bytes above sad_width are dropped
                        for (int b = 0; b < sad_width / 8; b++) begin
                            if (reg_bytecnt == bytecnt_width'(b)) begin
                                threshold[8*b +: 8] <= reg_datai;
                            end
                        end
                    end
                    addr_multiple_triggers: multiple_triggers <= reg_datai[0];
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: sad_core/sad_sequencer.sv
module sad_sequencer (
    input  logic                 adc_sampleclk,
    input  logic                 reset,
    input  sad_pkg::sample_t     adc_datain,
    input  logic                 armed_and_ready,
    input  logic                 active,
    input  sad_pkg::ref_array_t  ref_wave,
    output logic                 run,
    output sad_pkg::sample_t     sample_d,
    output sad_pkg::ref_array_t  ref_lane,
    output sad_pkg::lane_mask_t  lane_restart,
    output sad_pkg::lane_mask_t  lane_ready
);
    import sad_pkg::*;

    logic [lane_idx_width-1:0] master_counter;  // reference sample fed to lane 0
    logic                      counter_top;

    // the only place that decides whether the engine runs
    assign run = armed_and_ready && active;

    assign counter_top = master_counter == lane_idx_width'(ref_samples - 1);

    // run control
    // The restart ring idles with one bit at ref_samples-3. After j running
    // clocks it has rotated by j, so lane i sees its restart i+3 clocks after
    // run starts, which is where the first sample of that lane's window
    // reaches the accumulate stage.
    always_ff @(posedge adc_sampleclk) begin
        if (reset || !run) begin
            master_counter <= '0;
            lane_restart   <= lane_mask_t'(1) << (ref_samples - 3);
            lane_ready     <= '0;
        end else begin
            master_counter <= master_counter + 1'b1;  // wraps after the last sample
            lane_restart <= {lane_restart[ref_samples-2:0], lane_restart[ref_samples-1]};
            // lane 0 is ready after one full pass, the rest follow one per clock
            lane_ready   <= {lane_ready[ref_samples-2:0], lane_ready[0] | counter_top};
        end
    end

    // sample and reference chain
    // lane i sees the reference delayed by i, so lane i starts its window
    // on sample i of the run and then every ref_samples samples
    always_ff @(posedge adc_sampleclk) begin
        sample_d <= adc_datain;
        ref_lane <= {ref_lane[ref_samples-2:0], ref_wave[master_counter]};
    end

endmodule

// File: sad_core/sad_accumulators.sv
module sad_accumulators (
    input  logic                 adc_sampleclk,
    input  sad_pkg::sample_t     sample_d,
    input  sad_pkg::ref_array_t  ref_lane,
    input  sad_pkg::lane_mask_t  lane_restart,
    input  sad_pkg::lane_mask_t  lane_ready,
    input  sad_pkg::sad_t        threshold,
    output sad_pkg::lane_mask_t  lane_match,
    output sad_pkg::lane_mask_t  lane_ready_d
);
    import sad_pkg::*;

    sample_t    sample_r;      // shared by all lanes
    ref_array_t ref_r;
    lane_mask_t decision;      // sample above reference
    lane_mask_t restart_next;  // lane restarts on the following clock
    lane_mask_t ready_p1;
    lane_mask_t ready_p2;
    sad_t       incr     [ref_samples];
    sad_t       acc      [ref_samples];
    sad_t       acc_next [ref_samples];

    // the ring rotates by one, so next clock's restart is the neighbour's bit
    assign restart_next = {lane_restart[ref_samples-2:0], lane_restart[ref_samples-1]};

    // compare stage
    always_ff @(posedge adc_sampleclk) begin
        sample_r <= sample_d;
        ref_r    <= ref_lane;
        for (int i = 0; i < ref_samples; i++) begin
            decision[i] <= sample_d > ref_lane[i];
        end
    end

    // increment stage, always non-negative
    always_ff @(posedge adc_sampleclk) begin
        for (int i = 0; i < ref_samples; i++) begin
            if (decision[i]) begin
                incr[i] <= sad_t'(sample_r) - sad_t'(ref_r[i]);
            end else begin
                incr[i] <= sad_t'(ref_r[i]) - sad_t'(sample_r);
            end
        end
    end

    // sticks once the MSB is set
    always_comb begin
        for (int i = 0; i < ref_samples; i++) begin
            if (acc[i][sad_width-1]) begin
                acc_next[i] = acc[i];
            end else begin
                acc_next[i] = acc[i] + incr[i];
            end
        end
    end

    // accumulate and compare-out stage
    // The last sample of a window is added on the clock just before the
    // restart, so the finished sum is acc_next there and lane_match is
    // valid during the restart clock itself.
    always_ff @(posedge adc_sampleclk) begin
        for (int i = 0; i < ref_samples; i++) begin
            if (lane_restart[i]) begin
                acc[i] <= incr[i];  // first sample of a new window
            end else begin
                acc[i] <= acc_next[i];
            end
            lane_match[i] <= restart_next[i] && (acc_next[i] <= threshold);
        end
    end

    // ready follows the same three stages as the data
    always_ff @(posedge adc_sampleclk) begin
        ready_p1     <= lane_ready;
        ready_p2     <= ready_p1;
        lane_ready_d <= ready_p2;
    end

endmodule

// File: rtl/sad_trigger.sv
module sad_trigger (
    input  logic                adc_sampleclk,
    input  logic                reset,
    input  logic                run,
    input  logic                armed_and_ready,
    input  sad_pkg::lane_mask_t lane_match,
    input  sad_pkg::lane_mask_t lane_ready_d,
    input  logic                multiple_triggers,
    input  logic                clear_status,
    output logic                trigger,
    output logic                triggered,
    output logic [15:0]         num_triggers
);

    logic armed_r;
    logic arm_rise;   // new arming
    logic any_match;
    logic blocked;

    assign arm_rise  = armed_and_ready && !armed_r;
    assign any_match = |(lane_match & lane_ready_d);  // partial windows never count

    // single-shot mode, trigger is included since triggered lags it by a clock
    assign blocked = (triggered || trigger) && !multiple_triggers;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            trigger <= 1'b0;
            armed_r <= 1'b0;
        end else begin
            trigger <= run && any_match && !blocked;
            armed_r <= armed_and_ready;
        end
    end

    // status flag and count
    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_status || arm_rise) begin
            triggered    <= 1'b0;
            num_triggers <= '0;
        end else if (trigger) begin
            triggered    <= 1'b1;
            num_triggers <= num_triggers + 16'd1;  // wraps
        end
    end

endmodule

// File: rtl/sad_top.sv
module sad_top (
    input  logic                              adc_sampleclk,
    input  logic                              reset,
    input  sad_pkg::sample_t                  adc_datain,
    input  logic                              armed_and_ready,
    input  logic                              active,
    input  logic [7:0]                        reg_address,
    input  logic [sad_pkg::bytecnt_width-1:0] reg_bytecnt,
    input  logic [7:0]                        reg_datai,
    input  logic                              reg_read,
    input  logic                              reg_write,
    output logic [7:0]                        reg_datao,
    output logic                              trigger
);
    import sad_pkg::*;

    // register file outputs
    ref_array_t  ref_wave;
    sad_t        threshold;
    logic        multiple_triggers;
    logic        clear_status;

    // sequencer to accumulators
    logic        run;
    sample_t     sample_d;
    ref_array_t  ref_lane;
    lane_mask_t  lane_restart;
    lane_mask_t  lane_ready;

    // accumulators to trigger
    lane_mask_t  lane_match;
    lane_mask_t  lane_ready_d;

    // status back to the host
    logic        triggered;
    logic [15:0] num_triggers;

    sad_regs sad_regs_inst (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .reg_address       (reg_address),
        .reg_bytecnt       (reg_bytecnt),
        .reg_datai         (reg_datai),
        .reg_read          (reg_read),
        .reg_write         (reg_write),
        .triggered         (triggered),
        .num_triggers      (num_triggers),
        .reg_datao         (reg_datao),
        .ref_wave          (ref_wave),
        .threshold         (threshold),
        .multiple_triggers (multiple_triggers),
        .clear_status      (clear_status)
    );

    sad_sequencer sad_sequencer_inst (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .adc_datain      (adc_datain),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .ref_wave        (ref_wave),
        .run             (run),
        .sample_d        (sample_d),
        .ref_lane        (ref_lane),
        .lane_restart    (lane_restart),
        .lane_ready      (lane_ready)
    );

    sad_accumulators sad_accumulators_inst (
        .adc_sampleclk (adc_sampleclk),
        .sample_d      (sample_d),
        .ref_lane      (ref_lane),
        .lane_restart  (lane_restart),
        .lane_ready    (lane_ready),
        .threshold     (threshold),
        .lane_match    (lane_match),
        .lane_ready_d  (lane_ready_d)
    );

    sad_trigger sad_trigger_inst (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .run               (run),
        .armed_and_ready   (armed_and_ready),
        .lane_match        (lane_match),
        .lane_ready_d      (lane_ready_d),
        .multiple_triggers (multiple_triggers),
        .clear_status      (clear_status),
        .trigger           (trigger),
        .triggered         (triggered),
        .num_triggers      (num_triggers)
    );

endmodule

// File: verif/sad_chk.sv
module sad_chk (
    input logic adc_sampleclk,
    input logic reset,
    input logic run,
    input logic trigger,
    input logic triggered,
    input logic multiple_triggers,
    input logic clear_status
);

    int unsigned fail_count = 0;  // assertion failures so far

    // trigger drops one clock after run goes low
    trigger_needs_run: assert property (
        @(posedge adc_sampleclk) disable iff (reset) !run |=> !trigger
    ) else begin
        $error("trigger high one clock after run was low");
        fail_count++;
    end

    single_shot: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        (triggered && !multiple_triggers) |-> !$rose(trigger)
    ) else begin
        $error("second trigger while single-shot and already triggered");
        fail_count++;
    end

    clear_one_cycle: assert property (
        @(posedge adc_sampleclk) disable iff (reset) clear_status |=> !clear_status
    ) else begin
        $error("clear_status held longer than one clock");
        fail_count++;
    end

endmodule

bind sad_top sad_chk sad_chk_inst (
    .adc_sampleclk     (adc_sampleclk),
    .reset             (reset),
    .run               (run),
    .trigger           (trigger),
    .triggered         (triggered),
    .multiple_triggers (multiple_triggers),
    .clear_status      (clear_status)
);

// File: verif/sad_tb.sv
module sad_tb;
    import sad_pkg::*;

    typedef struct packed {
        sad_t        threshold;
        logic        multi;
        logic [3:0]  inserts;
        logic [7:0]  offset;     // added to every pattern sample
        logic [15:0] exp_count;
    } case_t;

    localparam int num_cases = 6;
    localparam int settle_limit = 200;

    logic                     adc_sampleclk = 1'b0;
    logic                     reset;
    sample_t                  adc_datain;
    logic                     armed_and_ready;
    logic                     active;
    logic [7:0]               reg_address;
    logic [bytecnt_width-1:0] reg_bytecnt;
    logic [7:0]               reg_datai;
    logic                     reg_read;
    logic                     reg_write;
    logic [7:0]               reg_datao;
    logic                     trigger;

    case_t       cases [num_cases];
    sample_t     ref_data [ref_samples];
    logic [31:0] rng_state;
    int          errors = 0;
    int          tests_run = 0;
    int          failed_tests = 0;
    int          pulse_count = 0;   // rising edges of trigger seen at the port
    logic        trigger_prev = 1'b0;

    sad_top sad_top_inst (.*);

    always #10 adc_sampleclk = ~adc_sampleclk;

    always @(negedge adc_sampleclk) begin
        if (trigger && !trigger_prev) pulse_count++;
        trigger_prev = trigger;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_sad(input string name, input sad_t got, input sad_t exp);
        if (got !== exp) begin
            $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $finish;
    endtask

    task automatic write_reg(input logic [7:0] addr, input int idx, input logic [7:0] data);
        @(negedge adc_sampleclk);
        reg_address = addr;
        reg_bytecnt = bytecnt_width'(idx);
        reg_datai   = data;
        reg_write   = 1'b1;
        @(negedge adc_sampleclk);
        reg_write   = 1'b0;
    endtask

    // read data is combinational, sampled a full cycle after the address
    task automatic read_reg(input logic [7:0] addr, input int idx, output logic [7:0] data);
        @(negedge adc_sampleclk);
        reg_address = addr;
        reg_bytecnt = bytecnt_width'(idx);
        reg_read    = 1'b1;
        @(negedge adc_sampleclk);
        data     = reg_datao;
        reg_read = 1'b0;
    endtask

    task automatic read_status(output logic [7:0] flags, output logic [15:0] count);
        logic [7:0] lo;
        logic [7:0] hi;
        read_reg(addr_status, 0, flags);
        read_reg(addr_status, 1, lo);
        read_reg(addr_status, 2, hi);
        count = {hi, lo};
    endtask

    task automatic arm(input logic level);
        @(negedge adc_sampleclk);
        armed_and_ready = level;
        active          = level;
    endtask

    task automatic configure(input sad_t thr, input logic multi);
        logic [31:0] thr_word;
        thr_word = 32'(thr);
        arm(1'b0);
        for (int b = 0; b < 4; b++) write_reg(addr_threshold, b, thr_word[8*b +: 8]);
        write_reg(addr_multiple_triggers, 0, {7'b0, multi});
    endtask

    task automatic drive_noise(input int n);
        for (int k = 0; k < n; k++) begin
            rng_state = xorshift(rng_state);
            @(negedge adc_sampleclk);
            adc_datain = {2'b11, rng_state[5:0]};  // 192..255, far from any reference
        end
    endtask

    // lead noise keeps patterns clear of the lane warm-up
    task automatic run_stream(input int inserts, input logic [7:0] offset);
        drive_noise(2 * ref_samples);
        for (int i = 0; i < inserts; i++) begin
            for (int k = 0; k < ref_samples; k++) begin
                @(negedge adc_sampleclk);
                adc_datain = ref_data[k] + offset;
            end
            drive_noise(ref_samples + 8);
        end
    endtask

    // done once trigger has stayed low for 8 clocks, twice the latency
    task automatic wait_settled(input string what);
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < 8 && cycles < settle_limit) begin
            @(negedge adc_sampleclk);
            cycles++;
            quiet = trigger ? 0 : quiet + 1;
        end
        if (quiet < 8) begin
            abort_run($sformatf("timeout: trigger kept firing after the stream in %s", what));
        end
    endtask

    task automatic test_readback();
        logic [7:0] data;
        sad_t       thr_read;
        int         start_errors;
        start_errors = errors;
        for (int k = 0; k < ref_samples; k++) write_reg(addr_reference, k, ref_data[k]);
        for (int k = 0; k < ref_samples; k++) begin
            read_reg(addr_reference, k, data);
            check_byte($sformatf("reference[%0d]", k), data, ref_data[k]);
        end
        for (int b = 0; b < 4; b++) write_reg(addr_threshold, b, 8'h3c + 8'(b * 8'h45));
        read_reg(addr_threshold, 0, data);
        thr_read[7:0] = data;
        read_reg(addr_threshold, 1, data);
        thr_read[15:8] = data;
        check_sad("threshold", thr_read, {8'h81, 8'h3c});
        read_reg(addr_threshold, 2, data);
        check_byte("threshold byte 2", data, 8'h00);  // beyond sad_width
        read_reg(addr_threshold, 3, data);
        check_byte("threshold byte 3", data, 8'h00);
        read_reg(addr_bits_per_sample, 0, data);
        check_byte("bits_per_sample", data, 8'd8);
        read_reg(addr_ref_samples, 0, data);
        check_byte("ref_samples", data, 8'd32);
        read_reg(addr_counter_width, 0, data);
        check_byte("counter_width", data, 8'd16);
        report_test("register readback", start_errors);
    endtask

    task automatic run_case(input int n, input case_t c);
        logic [7:0]  flags;
        logic [15:0] count;
        int          pulses_before;
        int          start_errors;
        start_errors = errors;
        configure(c.threshold, c.multi);
        pulses_before = pulse_count;
        arm(1'b1);
        run_stream(int'(c.inserts), c.offset);
        wait_settled($sformatf("case %0d", n));
        read_status(flags, count);
        check_count("num_triggers", count, c.exp_count);
        check_byte("status byte 0", flags, {7'b0, c.exp_count != 16'd0});
        check_count("trigger pulses", 16'(pulse_count - pulses_before), c.exp_count);
        report_test($sformatf("case %0d thr %0d multi %0d inserts %0d offset %0d", n,
                              c.threshold, c.multi, c.inserts, c.offset), start_errors);
    endtask

    task automatic test_status_clear(input logic by_rearm);
        logic [7:0]  flags;
        logic [15:0] count;
        int          start_errors;
        start_errors = errors;
        configure(sad_t'(0), 1'b0);
        arm(1'b1);
        run_stream(1, 8'd0);
        wait_settled("status clear setup");
        read_status(flags, count);
        check_count("num_triggers before clear", count, 16'd1);
        if (by_rearm) begin
            arm(1'b0);
            arm(1'b1);
        end else begin
            write_reg(addr_status, 0, 8'hff);
        end
        read_status(flags, count);
        check_byte("status byte 0", flags, 8'h00);
        check_count("num_triggers", count, 16'd0);
        report_test(by_rearm ? "status clear by re-arm" : "status clear by write",
                    start_errors);
    endtask

    initial begin
        rng_state       = 32'h4d21a7d1;
        reset           = 1'b1;
        adc_datain      = '0;
        armed_and_ready = 1'b0;
        active          = 1'b0;
        reg_address     = 8'h00;
        reg_bytecnt     = '0;
        reg_datai       = 8'h00;
        reg_read        = 1'b0;
        reg_write       = 1'b0;
        cases[0] = '{sad_t'(0), 1'b0, 4'd1, 8'd0, 16'd1};  // exact match
        cases[1] = '{sad_t'(0), 1'b0, 4'd0, 8'd0, 16'd0};  // pure noise
        cases[2] = '{sad_t'(ref_samples * 3), 1'b0, 4'd1, 8'd3, 16'd1};
        cases[3] = '{sad_t'(ref_samples * 3 - 1), 1'b0, 4'd1, 8'd3, 16'd0};
        cases[4] = '{sad_t'(0), 1'b0, 4'd3, 8'd0, 16'd1};  // single shot
        cases[5] = '{sad_t'(0), 1'b1, 4'd3, 8'd0, 16'd3};
        for (int k = 0; k < ref_samples; k++) begin
            rng_state   = xorshift(rng_state);
            ref_data[k] = {2'b00, rng_state[5:0]};
        end
        repeat (2) @(negedge adc_sampleclk);
        reset = 1'b0;
        test_readback();
        for (int n = 0; n < num_cases; n++) run_case(n, cases[n]);
        test_status_clear(1'b0);
        test_status_clear(1'b1);
        errors += int'(sad_top_inst.sad_chk_inst.fail_count);
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, failed_tests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: list.f
common/sad_pkg.sv
rtl/sad_regs.sv
sad_core/sad_sequencer.sv
sad_core/sad_accumulators.sv
rtl/sad_trigger.sv
rtl/sad_top.sv
verif/sad_chk.sv
verif/sad_tb.sv

// File: run.sh
#!/bin/sh
# build and run the SAD trigger testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module sad_tb -Mdir obj_dir -o sad_sim

./obj_dir/sad_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
    echo "result: PASS"
    exit 0
fi
echo "result: FAIL"
exit 1
